//--- hw/fl_pkg.sv
// Shared definitions for the FrameLink channel multiplexer
// DATA_WIDTH is expected to be a multiple of 8
// Both width helpers return at least 1 so that ports never collapse
// to zero width, even for 8-bit data or a single channel

package fl_pkg;

  // ----------------------------------------------------------
  // Arbiter state
  // ----------------------------------------------------------
  typedef enum logic {
    ARB_IDLE  = 1'b0,  // No frame granted
    ARB_FRAME = 1'b1   // Frame in progress on granted channel
  } fl_arb_state_t;

  // ----------------------------------------------------------
  // Width helpers
  // ----------------------------------------------------------

  // Byte remainder field, log2 of bytes per word
  function automatic int fl_drem_width(input int data_width);
    int bytes;
    bytes = data_width / 8;
    if (bytes <= 2) return 1;
    return $clog2(bytes);
  endfunction

  // Channel index field
  function automatic int fl_chan_width(input int channels);
    if (channels <= 2) return 1;
    return $clog2(channels);
  endfunction

endpackage

//--- hw/fl_rr_arbiter.sv
// Round-robin FrameLink arbiter, frame by frame
// A channel is granted only when it presents a word with sof_n low
// One idle cycle separates consecutive frames on the output
// The output word is combinational from the granted receive port
// Frame length is not checked; a frame without eof holds the grant
`timescale 1ns/100ps

module fl_rr_arbiter import fl_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int CHANNELS   = 4,
  localparam int DREM_W    = fl_drem_width(DATA_WIDTH),
  localparam int CHAN_W    = fl_chan_width(CHANNELS)
) (
  input  logic                           clk,
  input  logic                           rst_n,

  // Receive ports, packed per channel
  input  logic [CHANNELS*DATA_WIDTH-1:0] rx_data,
  input  logic [CHANNELS*DREM_W-1:0]     rx_drem,
  input  logic [CHANNELS-1:0]            rx_sof_n,
  input  logic [CHANNELS-1:0]            rx_eof_n,
  input  logic [CHANNELS-1:0]            rx_sop_n,
  input  logic [CHANNELS-1:0]            rx_eop_n,
  input  logic [CHANNELS-1:0]            rx_src_rdy_n,
  output logic [CHANNELS-1:0]            rx_dst_rdy_n,

  // Tagged word towards the FIFO
  output logic [DATA_WIDTH-1:0]          arb_data,
  output logic [DREM_W-1:0]              arb_drem,
  output logic                           arb_sof_n,
  output logic                           arb_eof_n,
  output logic                           arb_sop_n,
  output logic                           arb_eop_n,
  output logic [CHAN_W-1:0]              arb_channel,
  output logic                           arb_src_rdy_n,
  input  logic                           arb_dst_rdy_n
);

  fl_arb_state_t     state;
  logic [CHAN_W-1:0] grant;
  logic [CHAN_W-1:0] ptr;
  logic [CHAN_W-1:0] next_ptr;

  logic              found;
  logic [CHAN_W-1:0] found_chan;
  logic              xfer;

  // ----------------------------------------------------------
  // Request search
  // ----------------------------------------------------------

  // First waiting frame start at or after the pointer
  always_comb begin
    int idx;
    found      = 1'b0;
    found_chan = ptr;
    for (int off = 0; off < CHANNELS; off++) begin
      idx = (int'(ptr) + off) % CHANNELS;
      if (!found && !rx_src_rdy_n[idx] && !rx_sof_n[idx]) begin
        found      = 1'b1;
        found_chan = CHAN_W'(idx);
      end
    end
  end

  // Channel after the one being served, wrapping at the top
  assign next_ptr = (grant == CHAN_W'(CHANNELS - 1)) ? '0 : grant + 1'b1;

  // ----------------------------------------------------------
  // Word forwarding
  // ----------------------------------------------------------
  always_comb begin
    arb_data      = rx_data[grant*DATA_WIDTH +: DATA_WIDTH];
    arb_drem      = rx_drem[grant*DREM_W +: DREM_W];
    arb_sof_n     = rx_sof_n[grant];
    arb_eof_n     = rx_eof_n[grant];
    arb_sop_n     = rx_sop_n[grant];
    arb_eop_n     = rx_eop_n[grant];
    arb_channel   = grant;

    // Nothing moves unless a frame is granted
    arb_src_rdy_n = 1'b1;
    rx_dst_rdy_n  = '1;
    if (state == ARB_FRAME) begin
      arb_src_rdy_n       = rx_src_rdy_n[grant];
      rx_dst_rdy_n[grant] = arb_dst_rdy_n;
    end
  end

  assign xfer = (state == ARB_FRAME) && !arb_src_rdy_n && !arb_dst_rdy_n;

  // ----------------------------------------------------------
  // Grant FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ARB_IDLE;
      grant <= '0;
      ptr   <= '0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (found) begin
            grant <= found_chan;
            state <= ARB_FRAME;
          end
        end
        ARB_FRAME: begin
          // Release after the last word of the frame
          if (xfer && !arb_eof_n) begin
            state <= ARB_IDLE;
            ptr   <= next_ptr;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

endmodule

//--- hw/fl_fifo.sv
// Synchronous FIFO for channel-tagged FrameLink words
// FIFO_DEPTH must be a power of two and at least 2
// Read side is fall-through: the head word is visible on buf_* one
// edge after it is written. Full is the only write back-pressure
`timescale 1ns/100ps

module fl_fifo import fl_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int CHANNELS   = 4,
  parameter int FIFO_DEPTH = 8,
  localparam int DREM_W    = fl_drem_width(DATA_WIDTH),
  localparam int CHAN_W    = fl_chan_width(CHANNELS)
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Write side
  input  logic [DATA_WIDTH-1:0] arb_data,
  input  logic [DREM_W-1:0]     arb_drem,
  input  logic                  arb_sof_n,
  input  logic                  arb_eof_n,
  input  logic                  arb_sop_n,
  input  logic                  arb_eop_n,
  input  logic [CHAN_W-1:0]     arb_channel,
  input  logic                  arb_src_rdy_n,
  output logic                  arb_dst_rdy_n,

  // Read side
  output logic [DATA_WIDTH-1:0] buf_data,
  output logic [DREM_W-1:0]     buf_drem,
  output logic                  buf_sof_n,
  output logic                  buf_eof_n,
  output logic                  buf_sop_n,
  output logic                  buf_eop_n,
  output logic [CHAN_W-1:0]     buf_channel,
  output logic                  buf_src_rdy_n,
  input  logic                  buf_dst_rdy_n
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);
  localparam int WORD_W = CHAN_W + 4 + DREM_W + DATA_WIDTH;

  logic [WORD_W-1:0] mem [FIFO_DEPTH];
  logic [WORD_W-1:0] wr_word;
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   count;
  logic              wr_en;
  logic              rd_en;

  // Word, markers and tag stored side by side
  assign wr_word = {arb_channel, arb_sof_n, arb_eof_n, arb_sop_n, arb_eop_n,
                    arb_drem, arb_data};

  assign {buf_channel, buf_sof_n, buf_eof_n, buf_sop_n, buf_eop_n,
          buf_drem, buf_data} = mem[rd_ptr];

  // ----------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------
  assign arb_dst_rdy_n = (count == (ADDR_W + 1)'(FIFO_DEPTH));
  assign buf_src_rdy_n = (count == '0);

  assign wr_en = !arb_src_rdy_n && !arb_dst_rdy_n;
  assign rd_en = !buf_src_rdy_n && !buf_dst_rdy_n;

  // ----------------------------------------------------------
  // Storage and pointers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous read and write leaves occupancy unchanged
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/fl_tx_demux.sv
// Registered FrameLink output stage onto the shared transmit bus
// Holds one word; only the held channel's src_rdy_n goes low and only
// that channel's dst_rdy_n is looked at. A new word loads on the same
// edge the held word leaves, so throughput is one word per cycle
`timescale 1ns/100ps

module fl_tx_demux import fl_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int CHANNELS   = 4,
  localparam int DREM_W    = fl_drem_width(DATA_WIDTH),
  localparam int CHAN_W    = fl_chan_width(CHANNELS)
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // From the FIFO
  input  logic [DATA_WIDTH-1:0] buf_data,
  input  logic [DREM_W-1:0]     buf_drem,
  input  logic                  buf_sof_n,
  input  logic                  buf_eof_n,
  input  logic                  buf_sop_n,
  input  logic                  buf_eop_n,
  input  logic [CHAN_W-1:0]     buf_channel,
  input  logic                  buf_src_rdy_n,
  output logic                  buf_dst_rdy_n,

  // Shared transmit bus
  output logic [DATA_WIDTH-1:0] tx_data,
  output logic [DREM_W-1:0]     tx_drem,
  output logic                  tx_sof_n,
  output logic                  tx_eof_n,
  output logic                  tx_sop_n,
  output logic                  tx_eop_n,
  output logic [CHAN_W-1:0]     tx_channel,
  output logic [CHANNELS-1:0]   tx_src_rdy_n,
  input  logic [CHANNELS-1:0]   tx_dst_rdy_n
);

  logic valid;
  logic leave;
  logic load;

  // Held word leaves when its own channel accepts it
  assign leave = valid && !tx_dst_rdy_n[tx_channel];

  // Register free, or freed on this edge
  assign buf_dst_rdy_n = valid && !leave;
  assign load          = !buf_src_rdy_n && !buf_dst_rdy_n;

  // One-cold source-ready decode
  always_comb begin
    tx_src_rdy_n = '1;
    if (valid) begin
      tx_src_rdy_n[tx_channel] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid      <= 1'b0;
      tx_channel <= '0;
    end else if (load) begin
      valid      <= 1'b1;
      tx_channel <= buf_channel;
    end else if (leave) begin
      valid      <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (load) begin
      tx_data  <= buf_data;
      tx_drem  <= buf_drem;
      tx_sof_n <= buf_sof_n;
      tx_eof_n <= buf_eof_n;
      tx_sop_n <= buf_sop_n;
      tx_eop_n <= buf_eop_n;
    end
  end

endmodule

//--- hw/fl_mux_top.sv
// FrameLink channel multiplexer
// CHANNELS receive ports merge frame by frame onto one transmit bus
// Frames are never interleaved; sop/eop markers pass unchanged
// Minimum receive to transmit latency is 2 cycles
// FIFO_DEPTH must be a power of two and at least 2
`timescale 1ns/100ps

module fl_mux_top import fl_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int CHANNELS   = 4,
  parameter int FIFO_DEPTH = 8,
  localparam int DREM_W    = fl_drem_width(DATA_WIDTH),
  localparam int CHAN_W    = fl_chan_width(CHANNELS)
) (
  input  logic                           clk,
  input  logic                           rst_n,

  // Receive ports
  input  logic [CHANNELS*DATA_WIDTH-1:0] rx_data,
  input  logic [CHANNELS*DREM_W-1:0]     rx_drem,
  input  logic [CHANNELS-1:0]            rx_sof_n,
  input  logic [CHANNELS-1:0]            rx_eof_n,
  input  logic [CHANNELS-1:0]            rx_sop_n,
  input  logic [CHANNELS-1:0]            rx_eop_n,
  input  logic [CHANNELS-1:0]            rx_src_rdy_n,
  output logic [CHANNELS-1:0]            rx_dst_rdy_n,

  // Shared transmit bus
  output logic [DATA_WIDTH-1:0]          tx_data,
  output logic [DREM_W-1:0]              tx_drem,
  output logic                           tx_sof_n,
  output logic                           tx_eof_n,
  output logic                           tx_sop_n,
  output logic                           tx_eop_n,
  output logic [CHAN_W-1:0]              tx_channel,
  output logic [CHANNELS-1:0]            tx_src_rdy_n,
  input  logic [CHANNELS-1:0]            tx_dst_rdy_n
);

  // ----------------------------------------------------------
  // Arbiter to FIFO
  // ----------------------------------------------------------
  logic [DATA_WIDTH-1:0] arb_data;
  logic [DREM_W-1:0]     arb_drem;
  logic                  arb_sof_n, arb_eof_n, arb_sop_n, arb_eop_n;
  logic [CHAN_W-1:0]     arb_channel;
  logic                  arb_src_rdy_n;
  logic                  arb_dst_rdy_n;

  // ----------------------------------------------------------
  // FIFO to output stage
  // ----------------------------------------------------------
  logic [DATA_WIDTH-1:0] buf_data;
  logic [DREM_W-1:0]     buf_drem;
  logic                  buf_sof_n, buf_eof_n, buf_sop_n, buf_eop_n;
  logic [CHAN_W-1:0]     buf_channel;
  logic                  buf_src_rdy_n;
  logic                  buf_dst_rdy_n;

  fl_rr_arbiter #(
    .DATA_WIDTH (DATA_WIDTH),
    .CHANNELS   (CHANNELS)
  ) fl_rr_arbiter_i (
    .clk, .rst_n,
    .rx_data, .rx_drem, .rx_sof_n, .rx_eof_n, .rx_sop_n, .rx_eop_n,
    .rx_src_rdy_n, .rx_dst_rdy_n,
    .arb_data, .arb_drem, .arb_sof_n, .arb_eof_n, .arb_sop_n, .arb_eop_n,
    .arb_channel, .arb_src_rdy_n, .arb_dst_rdy_n
  );

  fl_fifo #(
    .DATA_WIDTH (DATA_WIDTH),
    .CHANNELS   (CHANNELS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fl_fifo_i (
    .clk, .rst_n,
    .arb_data, .arb_drem, .arb_sof_n, .arb_eof_n, .arb_sop_n, .arb_eop_n,
    .arb_channel, .arb_src_rdy_n, .arb_dst_rdy_n,
    .buf_data, .buf_drem, .buf_sof_n, .buf_eof_n, .buf_sop_n, .buf_eop_n,
    .buf_channel, .buf_src_rdy_n, .buf_dst_rdy_n
  );

  fl_tx_demux #(
    .DATA_WIDTH (DATA_WIDTH),
    .CHANNELS   (CHANNELS)
  ) fl_tx_demux_i (
    .clk, .rst_n,
    .buf_data, .buf_drem, .buf_sof_n, .buf_eof_n, .buf_sop_n, .buf_eop_n,
    .buf_channel, .buf_src_rdy_n, .buf_dst_rdy_n,
    .tx_data, .tx_drem, .tx_sof_n, .tx_eof_n, .tx_sop_n, .tx_eop_n,
    .tx_channel, .tx_src_rdy_n, .tx_dst_rdy_n
  );

endmodule

//--- bench/fl_mux_checker.sv
// Concurrent checks on the shared transmit bus of the multiplexer
// Bound into fl_mux_top; all rules are sampled on the rising edge
// and are off while reset is low
`timescale 1ns/100ps

module fl_mux_checker import fl_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int CHANNELS   = 4,
  localparam int DREM_W    = fl_drem_width(DATA_WIDTH),
  localparam int CHAN_W    = fl_chan_width(CHANNELS)
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic [DATA_WIDTH-1:0] tx_data,
  input logic [DREM_W-1:0]     tx_drem,
  input logic                  tx_sof_n,
  input logic                  tx_eof_n,
  input logic                  tx_sop_n,
  input logic                  tx_eop_n,
  input logic [CHAN_W-1:0]     tx_channel,
  input logic [CHANNELS-1:0]   tx_src_rdy_n,
  input logic [CHANNELS-1:0]   tx_dst_rdy_n
);

  logic active;
  logic stalled;

  assign active  = (tx_src_rdy_n != {CHANNELS{1'b1}});
  assign stalled = active && tx_dst_rdy_n[tx_channel];

  // ----------------------------------------------------------
  // Transmit bus rules
  // ----------------------------------------------------------
  one_cold: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(~tx_src_rdy_n))
    else $error("more than one tx_src_rdy_n bit low");

  chan_agree: assert property (@(posedge clk) disable iff (!rst_n)
    active |-> !tx_src_rdy_n[tx_channel])
    else $error("tx_channel does not match the low tx_src_rdy_n bit");

  // Held word and channel frozen while the channel stalls
  hold_word: assert property (@(posedge clk) disable iff (!rst_n)
    stalled |=> $stable(tx_data) && $stable(tx_drem) && $stable(tx_channel) &&
                $stable({tx_sof_n, tx_eof_n, tx_sop_n, tx_eop_n}) &&
                !tx_src_rdy_n[tx_channel])
    else $error("held transmit word changed before its transfer");

endmodule

bind fl_mux_top fl_mux_checker #(
  .DATA_WIDTH (DATA_WIDTH),
  .CHANNELS   (CHANNELS)
) fl_mux_checker_i (
  .clk, .rst_n,
  .tx_data, .tx_drem, .tx_sof_n, .tx_eof_n, .tx_sop_n, .tx_eop_n,
  .tx_channel, .tx_src_rdy_n, .tx_dst_rdy_n
);

//--- bench/fl_mux_tb.sv
// Directed testbench for the FrameLink channel multiplexer
// Runs the DUT with its default parameters: 32-bit data, 4 channels
// Receive inputs change 10 ns after the rising edge; handshakes are
// sampled on the falling edge, where every DUT output is stable
// Stops at the first mismatch
`timescale 1ns/100ps

module fl_mux_tb import fl_pkg::*; ();

  localparam int DATA_WIDTH     = 32;
  localparam int CHANNELS       = 4;
  localparam int DREM_W         = fl_drem_width(DATA_WIDTH);
  localparam int CHAN_W         = fl_chan_width(CHANNELS);
  localparam int WORD_W         = CHAN_W + 4 + DREM_W + DATA_WIDTH;
  localparam int TOTAL_WORDS    = 160;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20 + 200;

  logic                           clk;
  logic                           rst_n;
  logic [CHANNELS*DATA_WIDTH-1:0] rx_data;
  logic [CHANNELS*DREM_W-1:0]     rx_drem;
  logic [CHANNELS-1:0]            rx_sof_n, rx_eof_n, rx_sop_n, rx_eop_n;
  logic [CHANNELS-1:0]            rx_src_rdy_n;
  logic [CHANNELS-1:0]            rx_dst_rdy_n;
  logic [DATA_WIDTH-1:0]          tx_data;
  logic [DREM_W-1:0]              tx_drem;
  logic                           tx_sof_n, tx_eof_n, tx_sop_n, tx_eop_n;
  logic [CHAN_W-1:0]              tx_channel;
  logic [CHANNELS-1:0]            tx_src_rdy_n;
  logic [CHANNELS-1:0]            tx_dst_rdy_n;

  integer            seed = 70021;
  logic              bp_en;
  logic              in_frame;
  int                frame_chan;
  logic              full_seen;
  logic [WORD_W-1:0] exp_q [CHANNELS][$];
  int                sof_order [$];

  fl_mux_top fl_mux_top_i (
    .clk, .rst_n,
    .rx_data, .rx_drem, .rx_sof_n, .rx_eof_n, .rx_sop_n, .rx_eop_n,
    .rx_src_rdy_n, .rx_dst_rdy_n,
    .tx_data, .tx_drem, .tx_sof_n, .tx_eof_n, .tx_sop_n, .tx_eop_n,
    .tx_channel, .tx_src_rdy_n, .tx_dst_rdy_n
  );

  always #50 clk = ~clk;

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #10;
    end
    check_equal(rx_dst_rdy_n, {CHANNELS{1'b1}}, "rx_dst_rdy_n during reset");
    check_equal(tx_src_rdy_n, {CHANNELS{1'b1}}, "tx_src_rdy_n during reset");
    rst_n = 1'b1;
    @(negedge clk);
    check_equal(rx_dst_rdy_n, {CHANNELS{1'b1}}, "rx_dst_rdy_n after reset");
    check_equal(tx_src_rdy_n, {CHANNELS{1'b1}}, "tx_src_rdy_n after reset");
    @(posedge clk);
    #10;
  endtask

  // One frame on one channel; eop closes each part and the frame
  task automatic send_frame(input int ch, input int len, input int part_len);
    logic                  taken;
    logic [DATA_WIDTH-1:0] data;
    logic [DREM_W-1:0]     drem;
    logic                  sof_n, eof_n, sop_n, eop_n;
    for (int w = 0; w < len; w++) begin
      data  = DATA_WIDTH'($random(seed));
      drem  = (w == len - 1) ? DREM_W'($random(seed)) : {DREM_W{1'b1}};
      sof_n = (w != 0);
      eof_n = (w != len - 1);
      sop_n = (w % part_len != 0);
      eop_n = !((w % part_len == part_len - 1) || (w == len - 1));
      rx_data[ch*DATA_WIDTH +: DATA_WIDTH] = data;
      rx_drem[ch*DREM_W +: DREM_W]         = drem;
      rx_sof_n[ch]     = sof_n;
      rx_eof_n[ch]     = eof_n;
      rx_sop_n[ch]     = sop_n;
      rx_eop_n[ch]     = eop_n;
      rx_src_rdy_n[ch] = 1'b0;
      do begin
        @(negedge clk);
        taken = !rx_dst_rdy_n[ch];
        @(posedge clk);
        #10;
      end while (!taken);
      exp_q[ch].push_back({CHAN_W'(ch), sof_n, eof_n, sop_n, eop_n, drem, data});
    end
    rx_src_rdy_n[ch] = 1'b1;
    rx_sof_n[ch]     = 1'b1;
    rx_eof_n[ch]     = 1'b1;
    rx_sop_n[ch]     = 1'b1;
    rx_eop_n[ch]     = 1'b1;
  endtask

  // Until every expected word has left the transmit bus
  task automatic wait_drain();
    logic busy;
    do begin
      @(negedge clk);
      busy = (tx_src_rdy_n != {CHANNELS{1'b1}});
      for (int c = 0; c < CHANNELS; c++) begin
        if (exp_q[c].size() != 0) busy = 1'b1;
      end
      @(posedge clk);
      #10;
    end while (busy);
  endtask

  // Random stall pattern per channel
  always @(posedge clk) begin
    #10;
    if (bp_en) begin
      tx_dst_rdy_n = CHANNELS'($random(seed));
    end else begin
      tx_dst_rdy_n = '0;
    end
  end

  // ----------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------
  always @(negedge clk) begin
    logic [WORD_W-1:0] got;
    logic [WORD_W-1:0] exp;
    if (!rst_n) begin
      in_frame = 1'b0;
    end else begin
      if (fl_mux_top_i.arb_dst_rdy_n) full_seen = 1'b1;
      for (int c = 0; c < CHANNELS; c++) begin
        if (!tx_src_rdy_n[c] && !tx_dst_rdy_n[c]) begin
          check_equal(tx_channel, c, "tx_channel against active src_rdy_n");
          check_equal(exp_q[c].size() != 0, 1, "word with nothing expected");
          got = {tx_channel, tx_sof_n, tx_eof_n, tx_sop_n, tx_eop_n, tx_drem, tx_data};
          exp = exp_q[c].pop_front();
          check_equal(got, exp, $sformatf("word on channel %0d", c));
          if (!tx_sof_n) begin
            check_equal(in_frame, 0, "sof inside an open frame");
            in_frame   = 1'b1;
            frame_chan = c;
            sof_order.push_back(c);
          end
          check_equal(in_frame, 1, "word outside a frame");
          check_equal(c, frame_chan, "frames interleaved");
          if (!tx_eof_n) in_frame = 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_single_frames();
    for (int ch = 0; ch < CHANNELS; ch++) begin
      sof_order.delete();
      send_frame(ch, 5, 5);
      wait_drain();
      check_equal(sof_order.size(), 1, "frame count, single frame");
      check_equal(sof_order[0], ch, "channel of single frame");
    end
  endtask

  // Fresh pointer, so grants go 0, 1, 2, 3
  task automatic test_all_pending();
    apply_reset();
    sof_order.delete();
    fork
      send_frame(0, 6, 6);
      send_frame(1, 6, 6);
      send_frame(2, 6, 6);
      send_frame(3, 6, 6);
    join
    wait_drain();
    check_equal(sof_order.size(), CHANNELS, "frame count, all pending");
    for (int c = 0; c < CHANNELS; c++) begin
      check_equal(sof_order[c], c, "round-robin grant order");
    end
  endtask

  task automatic test_back_pressure();
    full_seen = 1'b0;
    bp_en     = 1'b1;
    fork
      send_frame(0, 24, 24);
      send_frame(1, 24, 24);
      send_frame(2, 24, 24);
      send_frame(3, 24, 24);
    join
    wait_drain();
    bp_en = 1'b0;
    check_equal(full_seen, 1, "FIFO full under back-pressure");
  endtask

  task automatic test_multi_part();
    fork
      send_frame(1, 10, 4);
      send_frame(3, 10, 4);
    join
    wait_drain();
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    rx_data      = '0;
    rx_drem      = '0;
    rx_sof_n     = '1;
    rx_eof_n     = '1;
    rx_sop_n     = '1;
    rx_eop_n     = '1;
    rx_src_rdy_n = '1;
    tx_dst_rdy_n = '0;
    bp_en        = 1'b0;
    in_frame     = 1'b0;
    frame_chan   = 0;
    full_seen    = 1'b0;
    apply_reset();
    test_single_frames();
    test_all_pending();
    test_back_pressure();
    test_multi_part();
    $display("all tests passed");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: words stopped moving before the tests ended");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sim.f
hw/fl_pkg.sv
hw/fl_rr_arbiter.sv
hw/fl_fifo.sv
hw/fl_tx_demux.sv
hw/fl_mux_top.sv
bench/fl_mux_checker.sv
bench/fl_mux_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FrameLink multiplexer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module fl_mux_tb -f sim.f -o fl_mux_sim

# The simulator may exit non-zero on a failure; keep the log either way
status=0
./obj_dir/fl_mux_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation PASSED"
